// ==== flist.f ====
+incdir+include
rtl/hmr_pkg.sv
rtl/hmr_grp_if.sv
rtl/hmr_majority_voter.sv
rtl/hmr_tmr_group.sv
rtl/hmr_mode_ctrl.sv
rtl/hmr_core_router.sv
rtl/hmr_unit.sv
bench/tb_hmr_unit.sv

// ==== Makefile ====
# Verilator flow for the HMR unit and its testbench

TOP := tb_hmr_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== bench/tb_hmr_unit.sv ====
// HMR unit testbench comparing the DUT against a TMR reference model with concurrent assertions
`timescale 1ns/100ps
`include "hmr_config.svh"

module tb_hmr_unit
  import hmr_pkg::*;
();

  localparam int clk_period   = 8;
  localparam int reset_cycles = 16;
  localparam int test_cycles  = 320;
  localparam int watchdog_ns  = (reset_cycles + test_cycles) * clk_period + 400;
  localparam int bus_w        = $bits(bus_t);
  localparam int ng           = `HMR_NUM_GROUPS;
  localparam int nc           = `HMR_NUM_CORES;

  logic                       clk_i = 1'b0;
  logic                       rst_n_i;
  logic                       cfg_we_i;
  logic [`HMR_CFG_AW-1:0]     cfg_addr_i;
  logic [`HMR_DATA_WIDTH-1:0] cfg_wdata_i;
  logic [`HMR_DATA_WIDTH-1:0] cfg_rdata_o;
  logic [ng-1:0]              bus_vote_en_i;
  sys_in_t  [nc-1:0]          sys_in_i;
  sys_in_t  [nc-1:0]          core_in_o;
  nominal_t [nc-1:0]          core_nom_i;
  bus_t     [nc-1:0]          core_bus_i;
  nominal_t [nc-1:0]          sys_nom_o;
  bus_t     [nc-1:0]          sys_bus_o;
  logic [ng-1:0]              tmr_failure_o;
  logic [nc-1:0]              core_setback_o;

  // Reference model state
  logic [ng-1:0]              exp_tmr_en;
  logic [nc-1:0]              exp_setback;
  logic [ng-1:0]              exp_failure;
  mm_cnt_t                    exp_cnt [nc];

  // Reference model combinational view
  logic [bus_w-1:0]           nom_vote_wide [ng];
  nominal_t [ng-1:0]          vote_nom;
  bus_t     [ng-1:0]          vote_bus;
  sys_in_t  [nc-1:0]          exp_core_in;
  nominal_t [nc-1:0]          exp_nom;
  bus_t     [nc-1:0]          exp_bus;
  logic [nc-1:0]              mm_next;
  logic [`HMR_DATA_WIDTH-1:0] exp_rdata;

  logic [31:0]                rng_state = 32'hb1f1;
  logic [ng-1:0]              same_out;
  int                         errors = 0;

  hmr_unit dut_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_rdata_o    (cfg_rdata_o),
    .bus_vote_en_i  (bus_vote_en_i),
    .sys_in_i       (sys_in_i),
    .core_in_o      (core_in_o),
    .core_nom_i     (core_nom_i),
    .core_bus_i     (core_bus_i),
    .sys_nom_o      (sys_nom_o),
    .sys_bus_o      (sys_bus_o),
    .tmr_failure_o  (tmr_failure_o),
    .core_setback_o (core_setback_o)
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Count the ones among three copies per bit
  function automatic logic [bus_w-1:0] vote_of_three(input logic [bus_w-1:0] a,
                                                     input logic [bus_w-1:0] b,
                                                     input logic [bus_w-1:0] c);
    logic [bus_w-1:0] r;
    for (int i = 0; i < bus_w; i++) begin
      r[i] = (int'(a[i]) + int'(b[i]) + int'(c[i])) >= 2;
    end
    return r;
  endfunction

  // Core c sits in group c % groups at offset c / groups
  always_comb begin
    for (int g = 0; g < ng; g++) begin
      nom_vote_wide[g] = vote_of_three({33'b0, core_nom_i[g]}, {33'b0, core_nom_i[g + ng]},
                                       {33'b0, core_nom_i[g + 2 * ng]});
      vote_nom[g] = nom_vote_wide[g][31:0];
      vote_bus[g] = vote_of_three(core_bus_i[g], core_bus_i[g + ng], core_bus_i[g + 2 * ng]);
    end
    for (int c = 0; c < nc; c++) begin
      if (exp_tmr_en[c % ng]) begin
        exp_core_in[c] = sys_in_i[c % ng];
        exp_nom[c]     = (c / ng == 0) ? vote_nom[c % ng] : '0;
        exp_bus[c]     = (c / ng == 0) ? vote_bus[c % ng] : '0;
        mm_next[c]     = (core_nom_i[c] != vote_nom[c % ng]) ||
                         (bus_vote_en_i[c % ng] && (core_bus_i[c] != vote_bus[c % ng]));
      end else begin
        exp_core_in[c] = sys_in_i[c];
        exp_nom[c]     = core_nom_i[c];
        exp_bus[c]     = core_bus_i[c];
        mm_next[c]     = 1'b0;
      end
    end
    exp_rdata = '0;
    if (cfg_addr_i == 3'd0) begin
      exp_rdata = 32'(exp_tmr_en);
    end else if (cfg_addr_i <= 3'd6) begin
      exp_rdata = 32'(exp_cnt[cfg_addr_i - 3'd1]);
    end
  end

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exp_tmr_en  <= '0;
      exp_setback <= '0;
      exp_failure <= '0;
      for (int c = 0; c < nc; c++) begin
        exp_cnt[c] <= '0;
      end
    end else begin
      if (cfg_we_i && (cfg_addr_i == 3'd0)) begin
        exp_tmr_en <= cfg_wdata_i[ng-1:0];
      end
      exp_setback <= mm_next;
      for (int g = 0; g < ng; g++) begin
        exp_failure[g] <= mm_next[g] | mm_next[g + ng] | mm_next[g + 2 * ng];
      end
      for (int c = 0; c < nc; c++) begin
        if (cfg_we_i && (cfg_addr_i == 3'(c + 1))) begin
          exp_cnt[c] <= '0;
        end else if (exp_setback[c] && (exp_cnt[c] != 8'hff)) begin
          exp_cnt[c] <= exp_cnt[c] + 8'd1;
        end
      end
    end
  end

  // Everything is settled at the falling edge
  chk_core_in: assert property (@(negedge clk_i) core_in_o == exp_core_in)
    else begin
      errors = errors + 1;
      $display("Error at %0t: core_in_o = %h, expected %h", $time, core_in_o, exp_core_in);
    end
  chk_sys_nom: assert property (@(negedge clk_i) sys_nom_o == exp_nom)
    else begin
      errors = errors + 1;
      $display("Error at %0t: sys_nom_o = %h, expected %h", $time, sys_nom_o, exp_nom);
    end
  chk_sys_bus: assert property (@(negedge clk_i) sys_bus_o == exp_bus)
    else begin
      errors = errors + 1;
      $display("Error at %0t: sys_bus_o = %h, expected %h", $time, sys_bus_o, exp_bus);
    end
  chk_failure: assert property (@(negedge clk_i) tmr_failure_o == exp_failure)
    else begin
      errors = errors + 1;
      $display("Error at %0t: tmr_failure_o = %b, expected %b", $time, tmr_failure_o,
               exp_failure);
    end
  chk_setback: assert property (@(negedge clk_i) core_setback_o == exp_setback)
    else begin
      errors = errors + 1;
      $display("Error at %0t: core_setback_o = %b, expected %b", $time, core_setback_o,
               exp_setback);
    end
  chk_rdata: assert property (@(negedge clk_i) cfg_rdata_o == exp_rdata)
    else begin
      errors = errors + 1;
      $display("Error at %0t: cfg_rdata_o = %h, expected %h", $time, cfg_rdata_o, exp_rdata);
    end

  task automatic draw_word(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // One clock of stimulus with an optional corrupted core
  task automatic apply_cycle(input int bad_core, input bit bad_bus, input bit we,
                             input logic [2:0] addr, input logic [31:0] wdata);
    sys_in_t  [nc-1:0] sys_v;
    nominal_t [nc-1:0] nom_v;
    bus_t     [nc-1:0] bus_v;
    nominal_t          base_nom;
    bus_t              base_bus;
    logic [31:0]       mask;
    @(posedge clk_i);
    for (int c = 0; c < nc; c++) begin
      draw_word(sys_v[c]);
    end
    for (int g = 0; g < ng; g++) begin
      draw_word(base_nom);
      draw_word(base_bus.addr);
      draw_word(base_bus.wdata);
      base_bus.we = base_bus.addr[0];
      for (int k = 0; k < 3; k++) begin
        nom_v[g + k * ng] = base_nom;
        bus_v[g + k * ng] = base_bus;
        // Independent cores get unrelated outputs
        if (!same_out[g] && k != 0) begin
          draw_word(nom_v[g + k * ng]);
          draw_word(bus_v[g + k * ng].wdata);
        end
      end
    end
    if (bad_core >= 0) begin
      draw_word(mask);
      mask = mask | 32'h1;
      if (bad_bus) begin
        bus_v[bad_core].wdata = bus_v[bad_core].wdata ^ mask;
      end else begin
        nom_v[bad_core] = nom_v[bad_core] ^ mask;
      end
    end
    sys_in_i    <= sys_v;
    core_nom_i  <= nom_v;
    core_bus_i  <= bus_v;
    cfg_we_i    <= we;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= wdata;
  endtask

  task automatic idle_cycles(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      draw_word(r);
      apply_cycle(-1, 1'b0, 1'b0, r[2:0], '0);
    end
  endtask

  task automatic read_all();
    for (int a = 0; a < 8; a++) begin
      apply_cycle(-1, 1'b0, 1'b0, 3'(a), '0);
    end
  endtask

  initial begin
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    rst_n_i       = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_addr_i    = '0;
    cfg_wdata_i   = '0;
    bus_vote_en_i = '0;
    sys_in_i      = '0;
    core_nom_i    = '0;
    core_bus_i    = '0;
    same_out      = '0;
    repeat (reset_cycles) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Reset state and pass-through
    idle_cycles(10);
    read_all();

    // Group 0 into TMR while group 1 stays independent
    same_out[0] = 1'b1;
    apply_cycle(-1, 1'b0, 1'b1, 3'd0, 32'h1);
    idle_cycles(10);

    // Single-core nominal corruption in each offset
    apply_cycle(2, 1'b0, 1'b0, 3'd3, '0);
    idle_cycles(3);
    apply_cycle(4, 1'b0, 1'b0, 3'd5, '0);
    apply_cycle(-1, 1'b0, 1'b0, 3'd5, '0);
    apply_cycle(0, 1'b0, 1'b0, 3'd1, '0);
    apply_cycle(0, 1'b0, 1'b0, 3'd1, '0);
    idle_cycles(2);
    read_all();

    // Bus-only corruption with the bus vote off and then on
    apply_cycle(4, 1'b1, 1'b0, 3'd5, '0);
    idle_cycles(3);
    @(posedge clk_i);
    bus_vote_en_i <= 2'b01;
    apply_cycle(4, 1'b1, 1'b0, 3'd5, '0);
    idle_cycles(3);
    same_out[1] = 1'b1;
    apply_cycle(-1, 1'b0, 1'b1, 3'd0, 32'h3);
    apply_cycle(5, 1'b1, 1'b0, 3'd6, '0);
    apply_cycle(3, 1'b0, 1'b0, 3'd6, '0);
    idle_cycles(3);
    read_all();

    // Clear a counter and then clear against a same-cycle increment
    apply_cycle(-1, 1'b0, 1'b1, 3'd5, '0);
    apply_cycle(2, 1'b0, 1'b0, 3'd3, '0);
    apply_cycle(-1, 1'b0, 1'b1, 3'd3, '0);
    idle_cycles(3);
    read_all();

    // Back to independent cores where corruptions no longer flag
    apply_cycle(-1, 1'b0, 1'b1, 3'd0, 32'h0);
    same_out = '0;
    apply_cycle(1, 1'b0, 1'b0, 3'd2, '0);
    apply_cycle(4, 1'b1, 1'b0, 3'd5, '0);
    idle_cycles(5);

    // Random modes, writes and corruptions
    same_out = '1;
    for (int i = 0; i < 150; i++) begin
      draw_word(r);
      bus_vote_en_i <= r[13:12];
      apply_cycle((r[10:8] < 3'd6) ? int'(r[10:8]) : -1, r[11], r[3:0] == 4'd0, r[6:4],
                  {30'b0, r[15:14]});
    end
    idle_cycles(4);
    @(negedge clk_i);

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== rtl/hmr_unit.sv ====
// HMR unit top level wrapping six cores into two interleaved TMR groups
`timescale 1ns/100ps
`include "hmr_config.svh"

module hmr_unit
  import hmr_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  // Configuration port
  input  logic                           cfg_we_i,
  input  logic     [`HMR_CFG_AW-1:0]     cfg_addr_i,
  input  logic     [`HMR_DATA_WIDTH-1:0] cfg_wdata_i,
  output logic     [`HMR_DATA_WIDTH-1:0] cfg_rdata_o,

  input  logic     [`HMR_NUM_GROUPS-1:0] bus_vote_en_i,

  // System side and core side payloads
  input  sys_in_t  [`HMR_NUM_CORES-1:0]  sys_in_i,
  output sys_in_t  [`HMR_NUM_CORES-1:0]  core_in_o,
  input  nominal_t [`HMR_NUM_CORES-1:0]  core_nom_i,
  input  bus_t     [`HMR_NUM_CORES-1:0]  core_bus_i,
  output nominal_t [`HMR_NUM_CORES-1:0]  sys_nom_o,
  output bus_t     [`HMR_NUM_CORES-1:0]  sys_bus_o,

  output logic     [`HMR_NUM_GROUPS-1:0] tmr_failure_o,
  output logic     [`HMR_NUM_CORES-1:0]  core_setback_o
);

  logic [`HMR_NUM_GROUPS-1:0] tmr_en;

  hmr_grp_if grp_if [`HMR_NUM_GROUPS-1:0] ();

  hmr_mode_ctrl i_mode_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .tmr_en_o    (tmr_en),
    .grp         (grp_if)
  );

  for (genvar g = 0; g < `HMR_NUM_GROUPS; g++) begin : grp_g
    nominal_t [2:0] grp_nom;
    bus_t     [2:0] grp_bus;

    // Offset k of group g is core g + k * groups
    for (genvar k = 0; k < 3; k++) begin : gen_sel
      assign grp_nom[k] = core_nom_i[g + k * `HMR_NUM_GROUPS];
      assign grp_bus[k] = core_bus_i[g + k * `HMR_NUM_GROUPS];
    end

    hmr_tmr_group i_tmr_group (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .tmr_en_i      (tmr_en[g]),
      .bus_vote_en_i (bus_vote_en_i[g]),
      .nom_i         (grp_nom),
      .bus_i         (grp_bus),
      .grp           (grp_if[g])
    );
  end

  hmr_core_router i_core_router (
    .sys_in_i       (sys_in_i),
    .core_in_o      (core_in_o),
    .core_nom_i     (core_nom_i),
    .core_bus_i     (core_bus_i),
    .sys_nom_o      (sys_nom_o),
    .sys_bus_o      (sys_bus_o),
    .tmr_failure_o  (tmr_failure_o),
    .core_setback_o (core_setback_o),
    .grp            (grp_if)
  );

endmodule

// ==== rtl/hmr_core_router.sv ====
// HMR core router steering inputs to cores and voted or raw outputs to the system
`timescale 1ns/100ps
`include "hmr_config.svh"

module hmr_core_router
  import hmr_pkg::*;
(
  input  sys_in_t  [`HMR_NUM_CORES-1:0]  sys_in_i,
  output sys_in_t  [`HMR_NUM_CORES-1:0]  core_in_o,
  input  nominal_t [`HMR_NUM_CORES-1:0]  core_nom_i,
  input  bus_t     [`HMR_NUM_CORES-1:0]  core_bus_i,
  output nominal_t [`HMR_NUM_CORES-1:0]  sys_nom_o,
  output bus_t     [`HMR_NUM_CORES-1:0]  sys_bus_o,
  output logic     [`HMR_NUM_GROUPS-1:0] tmr_failure_o,
  output logic     [`HMR_NUM_CORES-1:0]  core_setback_o,
  hmr_grp_if.router                      grp [`HMR_NUM_GROUPS-1:0]
);

  for (genvar g = 0; g < `HMR_NUM_GROUPS; g++) begin : gen_grp
    assign tmr_failure_o[g] = grp[g].failure;
  end

  for (genvar c = 0; c < `HMR_NUM_CORES; c++) begin : gen_core
    // The interleaved layout makes the main core index equal the group index
    localparam int unsigned grp_id = c % `HMR_NUM_GROUPS;
    localparam int unsigned offset = c / `HMR_NUM_GROUPS;

    assign core_setback_o[c] = grp[grp_id].mismatch[offset];

    if (offset == 0) begin : gen_main
      // Main core keeps its own inputs in both modes
      assign core_in_o[c] = sys_in_i[c];
      assign sys_nom_o[c] = grp[grp_id].active ? grp[grp_id].voted_nom : core_nom_i[c];
      assign sys_bus_o[c] = grp[grp_id].active ? grp[grp_id].voted_bus : core_bus_i[c];
    end else begin : gen_replica
      // Replicas follow the main core's inputs while voting
      assign core_in_o[c] = grp[grp_id].active ? sys_in_i[grp_id] : sys_in_i[c];
      // Replica slots read zero in TMR mode
      assign sys_nom_o[c] = grp[grp_id].active ? nominal_t'('0) : core_nom_i[c];
      assign sys_bus_o[c] = grp[grp_id].active ? bus_t'('0) : core_bus_i[c];
    end
  end

endmodule

// ==== rtl/hmr_mode_ctrl.sv ====
// HMR mode controller with group TMR enables and per-core mismatch counters
`timescale 1ns/100ps
`include "hmr_config.svh"

module hmr_mode_ctrl
  import hmr_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       cfg_we_i,
  input  logic [`HMR_CFG_AW-1:0]     cfg_addr_i,
  input  logic [`HMR_DATA_WIDTH-1:0] cfg_wdata_i,
  output logic [`HMR_DATA_WIDTH-1:0] cfg_rdata_o,
  output logic [`HMR_NUM_GROUPS-1:0] tmr_en_o,
  hmr_grp_if.ctrl                    grp [`HMR_NUM_GROUPS-1:0]
);

  logic [`HMR_NUM_GROUPS-1:0] tmr_en_q;
  logic [`HMR_NUM_CORES-1:0]  core_mm;
  logic [`HMR_NUM_CORES-1:0]  cnt_clr;
  mm_cnt_t                    cnt_q [`HMR_NUM_CORES];

  // Offset k of group g is physical core g + k * groups
  for (genvar g = 0; g < `HMR_NUM_GROUPS; g++) begin : gen_grp_mm
    for (genvar k = 0; k < 3; k++) begin : gen_offset
      assign core_mm[g + k * `HMR_NUM_GROUPS] = grp[g].mismatch[k];
    end
  end

  // Group enables with bit g for group g
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tmr_en_q <= '0;
    end else if (cfg_we_i && (cfg_addr_i == '0)) begin
      tmr_en_q <= cfg_wdata_i[`HMR_NUM_GROUPS-1:0];
    end
  end

  assign tmr_en_o = tmr_en_q;

  for (genvar c = 0; c < `HMR_NUM_CORES; c++) begin : gen_cnt
    // Any write to the counter address clears it
    assign cnt_clr[c] = cfg_we_i && (cfg_addr_i == `HMR_CFG_AW'(c + 1));

    // Clear wins over a same-cycle increment
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q[c] <= '0;
      end else if (cnt_clr[c]) begin
        cnt_q[c] <= '0;
      end else if (core_mm[c] && (cnt_q[c] != '1)) begin
        cnt_q[c] <= cnt_q[c] + 1'b1;
      end
    end
  end

  // Combinational readback where unmapped addresses return zero
  always_comb begin
    cfg_rdata_o = '0;
    if (cfg_addr_i == '0) begin
      cfg_rdata_o[`HMR_NUM_GROUPS-1:0] = tmr_en_q;
    end
    for (int c = 0; c < `HMR_NUM_CORES; c++) begin
      if (cfg_addr_i == `HMR_CFG_AW'(c + 1)) begin
        cfg_rdata_o[`HMR_CNT_WIDTH-1:0] = cnt_q[c];
      end
    end
  end

endmodule

// ==== rtl/hmr_tmr_group.sv ====
// TMR group voting nominal and bus payloads and registering mismatch flags
`timescale 1ns/100ps

module hmr_tmr_group
  import hmr_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           tmr_en_i,
  input  logic           bus_vote_en_i,
  input  nominal_t [2:0] nom_i,
  input  bus_t     [2:0] bus_i,
  hmr_grp_if.grp         grp
);

  nominal_t    voted_nom;
  bus_t        voted_bus;
  core_flags_t nom_disagree;
  core_flags_t bus_disagree;
  core_flags_t mismatch_d;
  core_flags_t mismatch_q;
  logic        failure_q;

  hmr_majority_voter #(
    .payload_t (nominal_t)
  ) i_nom_voter (
    .a_i        (nom_i[0]),
    .b_i        (nom_i[1]),
    .c_i        (nom_i[2]),
    .majority_o (voted_nom),
    .disagree_o (nom_disagree)
  );

  hmr_majority_voter #(
    .payload_t (bus_t)
  ) i_bus_voter (
    .a_i        (bus_i[0]),
    .b_i        (bus_i[1]),
    .c_i        (bus_i[2]),
    .majority_o (voted_bus),
    .disagree_o (bus_disagree)
  );

  always_comb begin
    mismatch_d = nom_disagree;
    // Bus payload only joins the vote while enabled
    if (bus_vote_en_i) begin
      mismatch_d = mismatch_d | bus_disagree;
    end
    // Independent cores are allowed to differ
    if (!tmr_en_i) begin
      mismatch_d = '0;
    end
  end

  // Flags last one cycle unless the mismatch persists
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mismatch_q <= '0;
      failure_q  <= 1'b0;
    end else begin
      mismatch_q <= mismatch_d;
      failure_q  <= |mismatch_d;
    end
  end

  assign grp.voted_nom = voted_nom;
  assign grp.voted_bus = voted_bus;
  assign grp.active    = tmr_en_i;
  assign grp.mismatch  = mismatch_q;
  assign grp.failure   = failure_q;

endmodule

// ==== rtl/hmr_majority_voter.sv ====
// Bitwise three-way majority voter with a disagreement flag per input
`timescale 1ns/100ps

module hmr_majority_voter
  import hmr_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  payload_t    a_i,
  input  payload_t    b_i,
  input  payload_t    c_i,
  output payload_t    majority_o,
  output core_flags_t disagree_o
);

  payload_t majority;

  // Each bit follows at least two of the three inputs
  assign majority = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  assign majority_o = majority;

  // An input disagrees if any of its bits lost the vote
  always_comb begin
    disagree_o    = '0;
    disagree_o[0] = (a_i != majority);
    disagree_o[1] = (b_i != majority);
    disagree_o[2] = (c_i != majority);
  end

endmodule

// ==== rtl/hmr_grp_if.sv ====
// TMR group bundle carrying voted payloads, mode and mismatch status of one group
`timescale 1ns/100ps

interface hmr_grp_if
  import hmr_pkg::*;
();

  // Voted payloads of the group
  nominal_t    voted_nom;
  bus_t        voted_bus;

  // Group currently votes
  logic        active;

  // Registered disagreement per offset and its OR
  core_flags_t mismatch;
  logic        failure;

  modport grp (output voted_nom, voted_bus, active, mismatch, failure);

  modport router (input voted_nom, voted_bus, active, mismatch, failure);

  // Counters only need the mismatch bits
  modport ctrl (input mismatch);

endinterface

// ==== rtl/hmr_pkg.sv ====
// HMR shared types for core payloads, bus requests, counters and per-core flags
`include "hmr_config.svh"

package hmr_pkg;

  // System inputs of one core
  typedef logic [`HMR_DATA_WIDTH-1:0] sys_in_t;

  // Nominal core output
  typedef logic [`HMR_DATA_WIDTH-1:0] nominal_t;

  // Bus request of one core
  typedef struct packed {
    logic [`HMR_DATA_WIDTH-1:0] addr;
    logic [`HMR_DATA_WIDTH-1:0] wdata;
    logic                       we;
  } bus_t;

  // Saturating mismatch count
  typedef logic [`HMR_CNT_WIDTH-1:0] mm_cnt_t;

  // One bit per core offset in a group
  // Bit 0 is the main core
  typedef logic [2:0] core_flags_t;

endpackage

// ==== include/hmr_config.svh ====
// HMR unit configuration of core count, group count and register widths
`ifndef HMR_CONFIG_SVH
`define HMR_CONFIG_SVH

// Physical cores behind the wrapper
`define HMR_NUM_CORES 6

// TMR groups with cores interleaved across them
`define HMR_NUM_GROUPS 2

// Data, address and configuration word width
`define HMR_DATA_WIDTH 32

// Per-core mismatch counter width
`define HMR_CNT_WIDTH 8

// Configuration address width
// Group enables at 0 and core counters at 1 to 6
`define HMR_CFG_AW 3

`endif
